//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    // primary opcode field, instr[31:26]
    // only the encodings this block cares about are named
    typedef enum logic [5:0] {
        SPECIAL = 6'd0,
        REGIMM  = 6'd1,
        BEQ     = 6'd4,
        BNE     = 6'd5,
        BLEZ    = 6'd6,
        BGTZ    = 6'd7,
        // likely forms, delay slot squashed when not taken
        BEQL    = 6'd20,
        BNEL    = 6'd21,
        BLEZL   = 6'd22,
        BGTZL   = 6'd23
    } mipsOp_e;

    // rt field under REGIMM, instr[20:16]
    typedef enum logic [4:0] {
        BLTZ  = 5'd0,
        BGEZ  = 5'd1,
        BLTZL = 5'd2,
        BGEZL = 5'd3
    } regimmRt_e;

    // funct under SPECIAL that selects jr
    localparam logic [5:0] FUNCT_JR = 6'd8;

    // one instruction word in bytes
    localparam logic [31:0] INSTR_BYTES = 32'd4;

    // condition classes after decode
    // signed compares are all against zero on operand A
    typedef enum logic [2:0] {
        CODE_BEQ,
        CODE_BNE,
        CODE_BGE,
        CODE_BGT,
        CODE_BLE,
        CODE_BLT,
        CODE_JR,
        CODE_NONE
    } branchCode_e;

    // decoded branch kind
    typedef struct packed {
        logic        isBranch;
        branchCode_e branchCode;
    } branchType_t;

    // incoming candidate from the issue side
    // outA and outB already carry forwarded values
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] outA;
        logic [31:0] outB;
    } branchCand_t;

    // outgoing redirect record
    typedef struct packed {
        // taken branch, flush IF/ID and refetch
        logic        branchFlush;
        // untaken likely branch, kill the delay slot
        logic        delaySlotFlush;
        // where fetch continues
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- branchIntake.sv
`timescale 1ns/1ps
`default_nettype none

module branchIntake (
    input  logic                clk,
    input  logic                arstN,
    input  logic                candReq,
    input  cpuPkg::branchCand_t candData,
    input  logic                senderBusy,
    output logic                candAck,
    output cpuPkg::branchCand_t exeCand,
    output logic                exeValid
);

    // four-phase receive states
    typedef enum logic {
        IDLE,
        ACKED
    } intakeState_e;

    intakeState_e state;
    logic         capture;

    // accept only while idle and the result path is free
    assign capture = (state == IDLE) && candReq && !senderBusy;

    // ack is high exactly while in ACKED
    assign candAck = (state == ACKED);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            exeValid <= 1'b0;
        end else begin
            // single-cycle pulse per accepted candidate
            exeValid <= capture;
            case (state)
                IDLE: begin
                    if (capture) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // hold ack until source drops req
                    if (!candReq) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // execute-stage register, payload only
    always_ff @(posedge clk) begin
        if (capture) begin
            exeCand <= candData;
        end
    end

endmodule

`default_nettype wire

//--- branchDecode.sv
`timescale 1ns/1ps
`default_nettype none

module branchDecode (
    input  logic [31:0]         instr,
    output cpuPkg::branchType_t brType,
    output logic                isLikely,
    output logic [31:0]         offset
);

    logic [5:0] opcode;
    logic [4:0] rtCode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign rtCode = instr[20:16];
    assign funct  = instr[5:0];

    // 16-bit immediate, sign-extended, still in words
    assign offset = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // default is a plain non-branch word
        brType.isBranch   = 1'b0;
        brType.branchCode = cpuPkg::CODE_NONE;
        isLikely          = 1'b0;
        case (cpuPkg::mipsOp_e'(opcode))
            cpuPkg::SPECIAL: begin
                // only jr matters under special
                if (funct == cpuPkg::FUNCT_JR) begin
                    brType.isBranch   = 1'b1;
                    brType.branchCode = cpuPkg::CODE_JR;
                end
            end
            cpuPkg::REGIMM: begin
                case (cpuPkg::regimmRt_e'(rtCode))
                    cpuPkg::BLTZ, cpuPkg::BLTZL: begin
                        brType.isBranch   = 1'b1;
                        brType.branchCode = cpuPkg::CODE_BLT;
                        isLikely          = (rtCode == cpuPkg::BLTZL);
                    end
                    cpuPkg::BGEZ, cpuPkg::BGEZL: begin
                        brType.isBranch   = 1'b1;
                        brType.branchCode = cpuPkg::CODE_BGE;
                        isLikely          = (rtCode == cpuPkg::BGEZL);
                    end
                    // link forms and traps are not handled here
                    default: ;
                endcase
            end
            cpuPkg::BEQ, cpuPkg::BEQL: begin
                brType.isBranch   = 1'b1;
                brType.branchCode = cpuPkg::CODE_BEQ;
                isLikely          = (opcode == cpuPkg::BEQL);
            end
            cpuPkg::BNE, cpuPkg::BNEL: begin
                brType.isBranch   = 1'b1;
                brType.branchCode = cpuPkg::CODE_BNE;
                isLikely          = (opcode == cpuPkg::BNEL);
            end
            cpuPkg::BLEZ, cpuPkg::BLEZL: begin
                brType.isBranch   = 1'b1;
                brType.branchCode = cpuPkg::CODE_BLE;
                isLikely          = (opcode == cpuPkg::BLEZL);
            end
            cpuPkg::BGTZ, cpuPkg::BGTZL: begin
                brType.isBranch   = 1'b1;
                brType.branchCode = cpuPkg::CODE_BGT;
                isLikely          = (opcode == cpuPkg::BGTZL);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- branchSolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchSolve (
    input  cpuPkg::branchType_t brType,
    input  logic [31:0]         outA,
    input  logic [31:0]         outB,
    input  logic                isLikely,
    output logic                branchFlush,
    output logic                delaySlotFlush
);

    logic taken;
    logic aEqB;
    logic aZero;
    logic aNeg;

    // shared compare terms
    assign aEqB  = (outA == outB);
    assign aZero = (outA == 32'd0);
    // sign bit of A, signed compare with zero
    assign aNeg  = outA[31];

    always_comb begin
        if (!brType.isBranch) begin
            taken = 1'b0;
        end else begin
            case (brType.branchCode)
                cpuPkg::CODE_BEQ: taken = aEqB;
                cpuPkg::CODE_BNE: taken = !aEqB;
                // A >= 0
                cpuPkg::CODE_BGE: taken = !aNeg;
                // A > 0
                cpuPkg::CODE_BGT: taken = !aNeg && !aZero;
                // A <= 0
                cpuPkg::CODE_BLE: taken = aNeg || aZero;
                // A < 0
                cpuPkg::CODE_BLT: taken = aNeg;
                // register jump is unconditional
                cpuPkg::CODE_JR:  taken = 1'b1;
                default:          taken = 1'b0;
            endcase
        end
    end

    // taken branch refetches from the target
    assign branchFlush    = taken;
    // untaken likely kills its delay slot
    assign delaySlotFlush = brType.isBranch && isLikely && !taken;

endmodule

`default_nettype wire

//--- branchTarget.sv
`timescale 1ns/1ps
`default_nettype none

module branchTarget (
    input  logic [31:0]         pc,
    input  logic [31:0]         offset,
    input  logic [31:0]         outA,
    input  cpuPkg::branchType_t brType,
    input  logic                taken,
    output logic [31:0]         target
);

    logic [31:0] relTarget;
    logic [31:0] fallThrough;

    // relative to the delay slot, offset counted in words
    assign relTarget   = pc + cpuPkg::INSTR_BYTES + {offset[29:0], 2'b00};
    // skip the delay slot
    assign fallThrough = pc + (cpuPkg::INSTR_BYTES << 1);

    always_comb begin
        if (taken && brType.branchCode == cpuPkg::CODE_JR) begin
            // register target
            target = outA;
        end else if (taken) begin
            target = relTarget;
        end else begin
            // untaken or not a branch
            target = fallThrough;
        end
    end

endmodule

`default_nettype wire

//--- redirectSender.sv
`timescale 1ns/1ps
`default_nettype none

module redirectSender (
    input  logic              clk,
    input  logic              arstN,
    input  logic              load,
    input  cpuPkg::redirect_t record,
    input  logic              redirAck,
    output logic              redirReq,
    output cpuPkg::redirect_t redirData,
    output logic              busy
);

    // four-phase send states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAITLOW
    } sendState_e;

    sendState_e state;

    // req follows the state directly
    assign redirReq = (state == REQ);

    // busy from load until ack is seen low again
    // ack already low in WAITLOW frees the intake for this edge
    assign busy = load || (state == REQ) || ((state == WAITLOW) && redirAck);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (load) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // drop req once ack arrives
                    if (redirAck) begin
                        state <= WAITLOW;
                    end
                end
                WAITLOW: begin
                    if (!redirAck) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // record held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (load && state == IDLE) begin
            redirData <= record;
        end
    end

endmodule

`default_nettype wire

//--- branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                candReq,
    input  cpuPkg::branchCand_t candData,
    output logic                candAck,
    output logic                redirReq,
    input  logic                redirAck,
    output cpuPkg::redirect_t   redirData
);

    cpuPkg::branchCand_t exeCand;
    logic                exeValid;
    logic                senderBusy;
    cpuPkg::branchType_t brType;
    logic                isLikely;
    logic [31:0]         offset;
    logic                branchFlush;
    logic                delaySlotFlush;
    logic [31:0]         target;
    cpuPkg::redirect_t   record;

    // execute-stage capture
    branchIntake u_branchIntake (
        .clk        (clk),
        .arstN      (arstN),
        .candReq    (candReq),
        .candData   (candData),
        .senderBusy (senderBusy),
        .candAck    (candAck),
        .exeCand    (exeCand),
        .exeValid   (exeValid)
    );

    branchDecode u_branchDecode (
        .instr    (exeCand.instr),
        .brType   (brType),
        .isLikely (isLikely),
        .offset   (offset)
    );

    branchSolve u_branchSolve (
        .brType         (brType),
        .outA           (exeCand.outA),
        .outB           (exeCand.outB),
        .isLikely       (isLikely),
        .branchFlush    (branchFlush),
        .delaySlotFlush (delaySlotFlush)
    );

    // taken is the branch flush itself
    branchTarget u_branchTarget (
        .pc     (exeCand.pc),
        .offset (offset),
        .outA   (exeCand.outA),
        .brType (brType),
        .taken  (branchFlush),
        .target (target)
    );

    // redirect record packing
    assign record.branchFlush    = branchFlush;
    assign record.delaySlotFlush = delaySlotFlush;
    assign record.target         = target;

    // loaded on the edge that ends exeValid
    redirectSender u_redirectSender (
        .clk       (clk),
        .arstN     (arstN),
        .load      (exeValid),
        .record    (record),
        .redirAck  (redirAck),
        .redirReq  (redirReq),
        .redirData (redirData),
        .busy      (senderBusy)
    );

endmodule

`default_nettype wire

//--- branchUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit_assert (
    input wire logic              clk,
    input wire logic              arstN,
    input wire logic              candReq,
    input wire logic              candAck,
    input wire logic              redirReq,
    input wire logic              redirAck,
    input wire cpuPkg::redirect_t redirData
);

    // failing property evaluations so far
    int assertErrs = 0;

    // record must not move while the receiver has not answered
    redirStable: assert property (@(posedge clk) disable iff (!arstN)
        (redirReq && !redirAck) |=> $stable(redirData))
        else begin
            assertErrs++;
            $error("redirData changed while redirReq waits for redirAck");
        end

    // ack only ever answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(candAck) |-> $past(candReq))
        else begin
            assertErrs++;
            $error("candAck rose without candReq");
        end

    // taken and squashed are mutually exclusive
    flushExclusive: assert property (@(posedge clk) disable iff (!arstN)
        redirReq |-> !(redirData.branchFlush && redirData.delaySlotFlush))
        else begin
            assertErrs++;
            $error("branchFlush and delaySlotFlush both set");
        end

endmodule

bind branchUnit branchUnit_assert u_branchUnitAssert (
    .clk       (clk),
    .arstN     (arstN),
    .candReq   (candReq),
    .candAck   (candAck),
    .redirReq  (redirReq),
    .redirAck  (redirAck),
    .redirData (redirData)
);

`default_nettype wire

//--- branchUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit_tb;

    logic                clk;
    logic                arstN;
    logic                candReq;
    cpuPkg::branchCand_t candData;
    logic                candAck;
    logic                redirReq;
    logic                redirAck;
    cpuPkg::redirect_t   redirData;

    integer seed;
    int     numCands = 400;
    int     valueErrs = 0;
    int     latErrs = 0;
    int     protoErrs = 0;
    int     assertErrs = 0;
    int     reqRises = 0;
    int     cycles = 0;

    // stimulus, ack delays and expected results, all in send order
    cpuPkg::branchCand_t cands[$];
    int                  ackDelay[$];
    cpuPkg::redirect_t   expQ[$];

    branchUnit u_branchUnit (
        .clk       (clk),
        .arstN     (arstN),
        .candReq   (candReq),
        .candData  (candData),
        .candAck   (candAck),
        .redirReq  (redirReq),
        .redirAck  (redirAck),
        .redirData (redirData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // random 32-bit draw kept non-negative for modulo
    function automatic int pick(input int range);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % range;
    endfunction

    task automatic makeCandidate(output cpuPkg::branchCand_t c);
        int          form;
        logic [4:0]  rs;
        logic [15:0] imm;
        logic [31:0] r;
        rs  = $random(seed);
        imm = $random(seed);
        r   = $random(seed);
        form = pick(16);
        // 13 branch forms, a few slots left for random words
        case (form)
            0:  c.instr = {cpuPkg::BEQ, rs, r[4:0], imm};
            1:  c.instr = {cpuPkg::BNE, rs, r[4:0], imm};
            2:  c.instr = {cpuPkg::BLEZ, rs, 5'd0, imm};
            3:  c.instr = {cpuPkg::BGTZ, rs, 5'd0, imm};
            4:  c.instr = {cpuPkg::BEQL, rs, r[4:0], imm};
            5:  c.instr = {cpuPkg::BNEL, rs, r[4:0], imm};
            6:  c.instr = {cpuPkg::BLEZL, rs, 5'd0, imm};
            7:  c.instr = {cpuPkg::BGTZL, rs, 5'd0, imm};
            8:  c.instr = {cpuPkg::REGIMM, rs, cpuPkg::BLTZ, imm};
            9:  c.instr = {cpuPkg::REGIMM, rs, cpuPkg::BGEZ, imm};
            10: c.instr = {cpuPkg::REGIMM, rs, cpuPkg::BLTZL, imm};
            11: c.instr = {cpuPkg::REGIMM, rs, cpuPkg::BGEZL, imm};
            12: c.instr = {cpuPkg::SPECIAL, rs, 15'd0, cpuPkg::FUNCT_JR};
            default: c.instr = $random(seed);
        endcase
        c.pc   = {r[31:2], 2'b00};
        c.outA = $random(seed);
        c.outB = $random(seed);
        // bias toward equality, zero and sign corners
        case (pick(5))
            0: c.outB = c.outA;
            1: c.outA = 32'd0;
            2: c.outA[31] = 1'b1;
            3: c.outA = r[0] ? 32'hffff_ffff : 32'd1;
            default: ;
        endcase
    endtask

    // expected record straight from the resolution and target rules
    task automatic modelRedirect(input cpuPkg::branchCand_t c);
        logic [5:0]         op;
        logic [4:0]         rt;
        logic               isBr;
        logic               isJr;
        logic               likely;
        logic               taken;
        logic signed [31:0] a;
        logic [31:0]        offs;
        cpuPkg::redirect_t  e;
        op     = c.instr[31:26];
        rt     = c.instr[20:16];
        a      = c.outA;
        offs   = {{14{c.instr[15]}}, c.instr[15:0], 2'b00};
        isBr   = 1'b1;
        isJr   = 1'b0;
        likely = 1'b0;
        taken  = 1'b0;
        if (op == cpuPkg::SPECIAL && c.instr[5:0] == cpuPkg::FUNCT_JR) begin
            isJr  = 1'b1;
            taken = 1'b1;
        end else if (op == cpuPkg::REGIMM && rt <= 5'd3) begin
            likely = rt[1];
            taken  = rt[0] ? (a >= 0) : (a < 0);
        end else if (op == cpuPkg::BEQ || op == cpuPkg::BEQL) begin
            likely = (op == cpuPkg::BEQL);
            taken  = (c.outA == c.outB);
        end else if (op == cpuPkg::BNE || op == cpuPkg::BNEL) begin
            likely = (op == cpuPkg::BNEL);
            taken  = (c.outA != c.outB);
        end else if (op == cpuPkg::BLEZ || op == cpuPkg::BLEZL) begin
            likely = (op == cpuPkg::BLEZL);
            taken  = (a <= 0);
        end else if (op == cpuPkg::BGTZ || op == cpuPkg::BGTZL) begin
            likely = (op == cpuPkg::BGTZL);
            taken  = (a > 0);
        end else begin
            isBr = 1'b0;
        end
        e.branchFlush    = taken;
        e.delaySlotFlush = isBr && likely && !taken;
        if (taken && isJr) begin
            e.target = c.outA;
        end else if (taken) begin
            e.target = c.pc + cpuPkg::INSTR_BYTES + offs;
        end else begin
            // past the delay slot
            e.target = c.pc + 2 * cpuPkg::INSTR_BYTES;
        end
        expQ.push_back(e);
    endtask

    task automatic checkRedirect(input cpuPkg::redirect_t got, input cpuPkg::redirect_t want);
        if (got.branchFlush !== want.branchFlush) begin
            valueErrs++;
            $display("Fail redirData.branchFlush got %h expected %h",
                     got.branchFlush, want.branchFlush);
        end
        if (got.delaySlotFlush !== want.delaySlotFlush) begin
            valueErrs++;
            $display("Fail redirData.delaySlotFlush got %h expected %h",
                     got.delaySlotFlush, want.delaySlotFlush);
        end
        if (got.target !== want.target) begin
            valueErrs++;
            $display("Fail redirData.target got %h expected %h", got.target, want.target);
        end
    endtask

    task automatic checkLatency(input int got);
        if (got != 2) begin
            latErrs++;
            $display("Fail redirReq latency got %h expected %h", got, 2);
        end
    endtask

    task automatic driveCandidates();
        int n;
        for (n = 0; n < cands.size(); n++) begin
            candData = cands[n];
            candReq  = 1'b1;
            @(negedge clk);
            while (!candAck) @(negedge clk);
            // accepted, its result is now owed
            modelRedirect(cands[n]);
            candReq = 1'b0;
            // four-phase, wait for ack to drop before the next one
            @(negedge clk);
            while (candAck) @(negedge clk);
        end
    endtask

    task automatic collectRedirects();
        int n;
        for (n = 0; n < numCands; n++) begin
            @(negedge clk);
            while (!redirReq) @(negedge clk);
            if (expQ.size() == 0) begin
                protoErrs++;
                $display("Error: redirect arrived with no candidate outstanding");
            end else begin
                checkRedirect(redirData, expQ.pop_front());
            end
            // back-pressure, hold the ack off for a while
            repeat (ackDelay[n]) @(negedge clk);
            redirAck = 1'b1;
            @(negedge clk);
            while (redirReq) @(negedge clk);
            redirAck = 1'b0;
        end
    endtask

    // edges from capture to redirReq, capture edge counted as 1
    initial begin : handshakeMonitor
        logic prevAck;
        logic prevReq;
        logic latActive;
        int   latCount;
        prevAck   = 1'b0;
        prevReq   = 1'b0;
        latActive = 1'b0;
        latCount  = 0;
        forever begin
            @(negedge clk);
            if (arstN) begin
                if (latActive) latCount++;
                if (candAck && !prevAck) begin
                    latCount  = 1;
                    latActive = 1'b1;
                end
                if (redirReq && !prevReq) begin
                    reqRises++;
                    if (latActive) begin
                        checkLatency(latCount);
                    end else begin
                        protoErrs++;
                        $display("Error: redirReq rose with no accepted candidate");
                    end
                    latActive = 1'b0;
                end
            end
            prevAck = candAck;
            prevReq = redirReq;
        end
    end

    initial begin : watchdog
        while (cycles < numCands * 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("Error: timeout after %0d cycles with redirects still outstanding", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : mainFlow
        cpuPkg::branchCand_t c;
        int                  i;
        seed     = 32'h273a;
        arstN    = 1'b0;
        candReq  = 1'b0;
        candData = '0;
        redirAck = 1'b0;
        for (i = 0; i < numCands; i++) begin
            makeCandidate(c);
            cands.push_back(c);
            ackDelay.push_back(pick(6));
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        fork
            driveCandidates();
            collectRedirects();
        join
        // quiet period, any extra request means a duplicate
        repeat (20) @(negedge clk);
        if (reqRises != numCands) begin
            protoErrs++;
            $display("Error: saw %0d redirect requests for %0d candidates", reqRises, numCands);
        end
        if (expQ.size() != 0) begin
            protoErrs++;
            $display("Error: %0d expected redirects never arrived", expQ.size());
        end
        assertErrs = u_branchUnit.u_branchUnitAssert.assertErrs;
        $display("errors: value %0d, latency %0d, protocol %0d, assertion %0d",
                 valueErrs, latErrs, protoErrs, assertErrs);
        if (valueErrs + latErrs + protoErrs + assertErrs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
cpuPkg.sv
branchIntake.sv
branchDecode.sv
branchSolve.sv
branchTarget.sv
redirectSender.sv
branchUnit.sv
branchUnit_assert.sv
branchUnit_tb.sv
